// ==== hw/corePkg.sv ====
`default_nettype none

package corePkg;

    // --------------------------------------------------
    // Sizes
    localparam int DATA_W = 32;
    localparam int NUM_REGS = 8;        // r0 reads as zero.
    localparam int REG_W = 3;
    localparam int ROB_DEPTH = 16;
    localparam int SQN_W = 5;           // One bit above the ROB index.
    localparam int DISPATCH_DEPTH = 4;
    localparam int ALU_IQ_DEPTH = 4;
    localparam int MUL_IQ_DEPTH = 2;
    localparam int MUL_LATENCY = 3;
    localparam int IMM_W = 16;
    localparam int CRED_W = $clog2(ROB_DEPTH + 1);
    localparam int MUL_CNT_W = $clog2(MUL_LATENCY + 1);

    // --------------------------------------------------
    // Uop formats
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        MUL = 3'd6
    } opcode_t;

    typedef logic [SQN_W-1:0] sqN_t;

    typedef struct packed {
        logic valid;
        opcode_t op;
        logic [REG_W-1:0] dst;
        logic [REG_W-1:0] src1;
        logic [REG_W-1:0] src2;
        logic useImm;                   // Immediate replaces src2.
        logic [IMM_W-1:0] imm;
    } inUop_t;

    typedef struct packed {
        logic ready;
        sqN_t tag;                      // Producer while not ready.
        logic [DATA_W-1:0] value;
    } operand_t;

    typedef struct packed {
        logic valid;
        opcode_t op;
        sqN_t sqN;
        logic [REG_W-1:0] dst;
        operand_t opnd1;
        operand_t opnd2;
    } issUop_t;

    typedef struct packed {
        logic valid;
        sqN_t sqN;
        logic [REG_W-1:0] dst;
        logic [DATA_W-1:0] result;
    } resUop_t;

    typedef struct packed {
        logic valid;
        sqN_t sqN;
        logic [REG_W-1:0] dst;
        logic [DATA_W-1:0] value;
    } commitUop_t;

endpackage

`default_nettype wire

// ==== hw/intAlu.sv ====
`default_nettype none

module intAlu (
    input wire clk,
    input wire rst,
    input wire corePkg::issUop_t issue,
    output corePkg::resUop_t aluWb
);
    import corePkg::*;

    logic [DATA_W-1:0] opA;
    logic [DATA_W-1:0] opB;
    logic [DATA_W-1:0] aluOut;
    logic wbValid;
    sqN_t wbSqN;
    logic [REG_W-1:0] wbDst;
    logic [DATA_W-1:0] wbResult;

    assign opA = issue.opnd1.value;
    assign opB = issue.opnd2.value;

    always_comb begin
        case (issue.op)
            ADD: aluOut = opA + opB;
            SUB: aluOut = opA - opB;
            AND: aluOut = opA & opB;
            OR: aluOut = opA | opB;
            XOR: aluOut = opA ^ opB;
            SLL: aluOut = opA << opB[4:0];
            default: aluOut = '0;       // MUL goes to the multiplier.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        wbSqN <= issue.sqN;
        wbDst <= issue.dst;
        wbResult <= aluOut;
    end

    assign aluWb = '{valid: wbValid, sqN: wbSqN, dst: wbDst, result: wbResult};

endmodule

`default_nettype wire

// ==== hw/multiplier.sv ====
`default_nettype none

module multiplier (
    input wire clk,
    input wire rst,
    input wire corePkg::issUop_t issue,
    output logic busy,
    output corePkg::resUop_t mulWb
);
    import corePkg::*;

    logic [DATA_W-1:0] opA;
    logic [DATA_W-1:0] opB;
    sqN_t tagQ;
    logic [REG_W-1:0] dstQ;
    logic [MUL_CNT_W-1:0] cnt;
    logic done;
    logic [2*DATA_W-1:0] product;

    // Operands stay latched through the result cycle.
    assign product = opA * opB;
    assign busy = cnt != '0;
    assign mulWb = '{valid: done, sqN: tagQ, dst: dstQ, result: product[DATA_W-1:0]};

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            opA <= issue.opnd1.value;
            opB <= issue.opnd2.value;
            tagQ <= issue.sqN;
            dstQ <= issue.dst;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
            done <= 1'b0;
        end else begin
            done <= cnt == MUL_CNT_W'(1);
            if (issue.valid) begin
                cnt <= MUL_CNT_W'(MUL_LATENCY - 1);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // Queue hold must cover the whole multiply.
    assert property (@(posedge clk) disable iff (rst) issue.valid |-> !busy);

endmodule

`default_nettype wire

// ==== hw/issueQueue.sv ====
`default_nettype none

module issueQueue #(
    parameter int DEPTH = 4
) (
    input wire clk,
    input wire rst,
    input wire corePkg::issUop_t disp,
    input wire corePkg::resUop_t aluWb,
    input wire corePkg::resUop_t mulWb,
    input wire hold,
    output corePkg::issUop_t issue,
    output logic freeCredit
);
    import corePkg::*;

    issUop_t slots [DEPTH];
    logic [DEPTH-1:0] used;
    logic [$clog2(DEPTH)-1:0] sel;
    logic [$clog2(DEPTH)-1:0] freeIdx;
    logic found;

    function automatic operand_t wake(input operand_t opnd);
        operand_t res;
        res = opnd;
        if (!opnd.ready && aluWb.valid && aluWb.sqN == opnd.tag) begin
            res.ready = 1'b1;
            res.value = aluWb.result;
        end
        if (!opnd.ready && mulWb.valid && mulWb.sqN == opnd.tag) begin
            res.ready = 1'b1;
            res.value = mulWb.result;
        end
        return res;
    endfunction

    // --------------------------------------------------
    // Oldest ready entry wins.
    always_comb begin
        found = 1'b0;
        sel = '0;
        freeIdx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!used[i]) begin
                freeIdx = $clog2(DEPTH)'(i);  // Lowest free slot.
            end
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (used[i] && slots[i].opnd1.ready && slots[i].opnd2.ready &&
                (!found || $signed(slots[i].sqN - slots[sel].sqN) < 0)) begin
                found = 1'b1;
                sel = $clog2(DEPTH)'(i);
            end
        end
        issue = slots[sel];
        issue.valid = found && !hold;
    end

    assign freeCredit = issue.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            used <= '0;
        end else begin
            if (issue.valid) begin
                used[sel] <= 1'b0;
            end
            if (disp.valid) begin
                used[freeIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            slots[i].opnd1 <= wake(slots[i].opnd1);
            slots[i].opnd2 <= wake(slots[i].opnd2);
        end
        if (disp.valid) begin
            slots[freeIdx] <= disp;     // Same-cycle results already captured upstream.
        end
    end

    // Dispatch credits keep the queue from overflowing.
    assert property (@(posedge clk) disable iff (rst) disp.valid |-> !(&used));

endmodule

`default_nettype wire

// ==== hw/reorderBuffer.sv ====
`default_nettype none

module reorderBuffer (
    input wire clk,
    input wire rst,
    input wire corePkg::resUop_t alloc,
    input wire corePkg::resUop_t aluWb,
    input wire corePkg::resUop_t mulWb,
    input wire corePkg::sqN_t readSqN1,
    input wire corePkg::sqN_t readSqN2,
    input wire [corePkg::REG_W-1:0] readReg1,
    input wire [corePkg::REG_W-1:0] readReg2,
    output logic readReady1,
    output logic readReady2,
    output logic [corePkg::DATA_W-1:0] readVal1,
    output logic [corePkg::DATA_W-1:0] readVal2,
    output logic [corePkg::DATA_W-1:0] regVal1,
    output logic [corePkg::DATA_W-1:0] regVal2,
    output logic robFree,
    output corePkg::commitUop_t commit
);
    import corePkg::*;

    logic [ROB_DEPTH-1:0] entValid;
    logic [ROB_DEPTH-1:0] entDone;
    logic [REG_W-1:0] entDst [ROB_DEPTH];
    logic [DATA_W-1:0] entVal [ROB_DEPTH];
    logic [DATA_W-1:0] archRegs [NUM_REGS];
    sqN_t headSqN;
    logic [SQN_W-2:0] headIdx;

    assign headIdx = headSqN[SQN_W-2:0];
    assign commit = '{valid: entValid[headIdx] && entDone[headIdx], sqN: headSqN,
                      dst: entDst[headIdx], value: entVal[headIdx]};
    assign robFree = commit.valid;

    // --------------------------------------------------
    // Operand reads for dispatch
    assign readReady1 = entValid[readSqN1[SQN_W-2:0]] && entDone[readSqN1[SQN_W-2:0]];
    assign readReady2 = entValid[readSqN2[SQN_W-2:0]] && entDone[readSqN2[SQN_W-2:0]];
    assign readVal1 = entVal[readSqN1[SQN_W-2:0]];
    assign readVal2 = entVal[readSqN2[SQN_W-2:0]];
    assign regVal1 = (readReg1 == '0) ? '0 : archRegs[readReg1];
    assign regVal2 = (readReg2 == '0) ? '0 : archRegs[readReg2];

    always_ff @(posedge clk) begin
        if (rst) begin
            entValid <= '0;
            entDone <= '0;
            headSqN <= '0;
        end else begin
            if (commit.valid) begin
                entValid[headIdx] <= 1'b0;
                headSqN <= headSqN + 1'b1;
            end
            if (alloc.valid) begin
                entValid[alloc.sqN[SQN_W-2:0]] <= 1'b1;
                entDone[alloc.sqN[SQN_W-2:0]] <= 1'b0;
            end
            if (aluWb.valid) begin
                entDone[aluWb.sqN[SQN_W-2:0]] <= 1'b1;
            end
            if (mulWb.valid) begin
                entDone[mulWb.sqN[SQN_W-2:0]] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc.valid) begin
            entDst[alloc.sqN[SQN_W-2:0]] <= alloc.dst;
        end
        if (aluWb.valid) begin
            entVal[aluWb.sqN[SQN_W-2:0]] <= aluWb.result;
        end
        if (mulWb.valid) begin
            entVal[mulWb.sqN[SQN_W-2:0]] <= mulWb.result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                archRegs[i] <= '0;
            end
        end else if (commit.valid && commit.dst != '0) begin
            archRegs[commit.dst] <= commit.value;
        end
    end

    // Results only return for uops still in flight.
    assert property (@(posedge clk) disable iff (rst) aluWb.valid |-> entValid[aluWb.sqN[SQN_W-2:0]]);
    assert property (@(posedge clk) disable iff (rst) mulWb.valid |-> entValid[mulWb.sqN[SQN_W-2:0]]);

endmodule

`default_nettype wire

// ==== hw/dispatchCtrl.sv ====
`default_nettype none

module dispatchCtrl (
    input wire clk,
    input wire rst,
    input wire corePkg::inUop_t inUop,
    input wire aluFree,
    input wire mulFree,
    input wire robFree,
    input wire corePkg::resUop_t aluWb,
    input wire corePkg::resUop_t mulWb,
    input wire corePkg::commitUop_t commit,
    input wire readReady1,
    input wire readReady2,
    input wire [corePkg::DATA_W-1:0] readVal1,
    input wire [corePkg::DATA_W-1:0] readVal2,
    input wire [corePkg::DATA_W-1:0] regVal1,
    input wire [corePkg::DATA_W-1:0] regVal2,
    output logic credit,
    output corePkg::issUop_t aluDisp,
    output corePkg::issUop_t mulDisp,
    output corePkg::resUop_t alloc,
    output corePkg::sqN_t readSqN1,
    output corePkg::sqN_t readSqN2,
    output logic [corePkg::REG_W-1:0] readReg1,
    output logic [corePkg::REG_W-1:0] readReg2
);
    import corePkg::*;

    inUop_t fifo [DISPATCH_DEPTH];
    logic [$clog2(DISPATCH_DEPTH)-1:0] wrPtr;
    logic [$clog2(DISPATCH_DEPTH)-1:0] rdPtr;
    logic [CRED_W-1:0] count;
    inUop_t head;

    sqN_t nextSqN;
    logic [NUM_REGS-1:0] renPend;
    sqN_t renTag [NUM_REGS];
    logic [CRED_W-1:0] aluCred;
    logic [CRED_W-1:0] mulCred;
    logic [CRED_W-1:0] robCred;

    logic isMul;
    logic canDisp;
    issUop_t dispUop;

    function automatic operand_t resolve(input logic pend, input sqN_t tag, input logic robRdy,
                                         input logic [DATA_W-1:0] robVal,
                                         input logic [DATA_W-1:0] archVal);
        operand_t opnd;
        opnd.ready = 1'b1;
        opnd.tag = tag;
        opnd.value = archVal;
        if (pend) begin
            if (robRdy) begin
                opnd.value = robVal;
            end else if (aluWb.valid && aluWb.sqN == tag) begin
                opnd.value = aluWb.result;
            end else if (mulWb.valid && mulWb.sqN == tag) begin
                opnd.value = mulWb.result;
            end else begin
                opnd.ready = 1'b0;      // Queue wakes it up later.
            end
        end
        return opnd;
    endfunction

    assign head = fifo[rdPtr];
    assign isMul = head.op == MUL;
    assign canDisp = count != '0 && robCred != '0 && (isMul ? mulCred != '0 : aluCred != '0);
    assign credit = canDisp;

    assign readReg1 = head.src1;
    assign readReg2 = head.src2;
    assign readSqN1 = renTag[head.src1];
    assign readSqN2 = renTag[head.src2];

    always_comb begin
        dispUop.valid = canDisp;
        dispUop.op = head.op;
        dispUop.sqN = nextSqN;
        dispUop.dst = head.dst;
        dispUop.opnd1 = resolve(renPend[head.src1], readSqN1, readReady1, readVal1, regVal1);
        if (head.useImm) begin
            dispUop.opnd2 = '{ready: 1'b1, tag: '0, value: DATA_W'(head.imm)};
        end else begin
            dispUop.opnd2 = resolve(renPend[head.src2], readSqN2, readReady2, readVal2, regVal2);
        end
        aluDisp = dispUop;
        aluDisp.valid = canDisp && !isMul;
        mulDisp = dispUop;
        mulDisp.valid = canDisp && isMul;
    end

    assign alloc = '{valid: canDisp, sqN: nextSqN, dst: head.dst, result: '0};

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            nextSqN <= '0;
            renPend <= '0;
            aluCred <= CRED_W'(ALU_IQ_DEPTH);
            mulCred <= CRED_W'(MUL_IQ_DEPTH);
            robCred <= CRED_W'(ROB_DEPTH);
        end else begin
            if (inUop.valid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (canDisp) begin
                rdPtr <= rdPtr + 1'b1;
                nextSqN <= nextSqN + 1'b1;
            end
            count <= count + CRED_W'(inUop.valid) - CRED_W'(canDisp);
            aluCred <= aluCred + CRED_W'(aluFree) - CRED_W'(canDisp && !isMul);
            mulCred <= mulCred + CRED_W'(mulFree) - CRED_W'(canDisp && isMul);
            robCred <= robCred + CRED_W'(robFree) - CRED_W'(canDisp);

            if (commit.valid && renTag[commit.dst] == commit.sqN) begin
                renPend[commit.dst] <= 1'b0;
            end
            if (canDisp && head.dst != '0) begin
                renPend[head.dst] <= 1'b1;  // Newer producer wins.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inUop.valid) begin
            fifo[wrPtr] <= inUop;
        end
        if (canDisp) begin
            renTag[head.dst] <= nextSqN;
        end
    end

    // --------------------------------------------------
    // A returned credit always matches an earlier spend.
    assert property (@(posedge clk) disable iff (rst) aluFree |-> aluCred < CRED_W'(ALU_IQ_DEPTH));
    assert property (@(posedge clk) disable iff (rst) mulFree |-> mulCred < CRED_W'(MUL_IQ_DEPTH));
    assert property (@(posedge clk) disable iff (rst) robFree |-> robCred < CRED_W'(ROB_DEPTH));
    assert property (@(posedge clk) disable iff (rst)
        inUop.valid |-> count < CRED_W'(DISPATCH_DEPTH));

endmodule

`default_nettype wire

// ==== hw/coreTop.sv ====
`default_nettype none

module coreTop (
    input wire clk,
    input wire rst,
    input wire corePkg::inUop_t inUop,
    output logic credit,
    output corePkg::commitUop_t commit
);
    import corePkg::*;

    issUop_t aluDisp;
    issUop_t mulDisp;
    issUop_t aluIssue;
    issUop_t mulIssue;
    resUop_t aluWb;
    resUop_t mulWb;
    resUop_t alloc;
    logic aluFree;
    logic mulFree;
    logic robFree;
    logic mulBusy;

    sqN_t readSqN1;
    sqN_t readSqN2;
    logic [REG_W-1:0] readReg1;
    logic [REG_W-1:0] readReg2;
    logic readReady1;
    logic readReady2;
    logic [DATA_W-1:0] readVal1;
    logic [DATA_W-1:0] readVal2;
    logic [DATA_W-1:0] regVal1;
    logic [DATA_W-1:0] regVal2;

    dispatchCtrl dispatch (.*);

    // --------------------------------------------------
    // Issue and execute
    issueQueue #(.DEPTH(ALU_IQ_DEPTH)) aluIq (
        .disp(aluDisp),
        .hold(1'b0),
        .issue(aluIssue),
        .freeCredit(aluFree),
        .*
    );

    issueQueue #(.DEPTH(MUL_IQ_DEPTH)) mulIq (
        .disp(mulDisp),
        .hold(mulBusy),                 // Multiplier is not pipelined.
        .issue(mulIssue),
        .freeCredit(mulFree),
        .*
    );

    intAlu alu (
        .issue(aluIssue),
        .*
    );

    multiplier mul (
        .issue(mulIssue),
        .busy(mulBusy),
        .*
    );

    reorderBuffer rob (.*);

endmodule

`default_nettype wire

// ==== dv/tbCore.sv ====
`default_nettype none

module tbCore;
    import corePkg::*;

    localparam int MAX_LINE = 160;

    logic clk = 1'b0;
    logic rst;
    inUop_t inUop;
    logic credit;
    commitUop_t commit;

    inUop_t uops [$];
    int gaps [$];
    logic [REG_W-1:0] expDst [$];
    logic [DATA_W-1:0] expVal [$];

    int checkErrors = 0;
    int runErrors = 0;
    int cycles = 0;
    int cycleLimit = 0;
    int sentCnt = 0;
    int returnedCnt = 0;
    int commitCnt = 0;
    logic [SQN_W-1:0] expSqN = '0;

    coreTop coreTop_inst (
        .clk(clk),
        .rst(rst),
        .inUop(inUop),
        .credit(credit),
        .commit(commit)
    );

    initial begin
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic int creditsHeld();
        return DISPATCH_DEPTH - sentCnt + returnedCnt;
    endfunction

    // --------------------------------------------------
    // Trace reader
    task automatic loadTrace();
        int fd;
        int n;
        logic [7:0] tag;
        logic [8*MAX_LINE-1:0] rest;
        logic [2:0] op;
        logic [REG_W-1:0] dst;
        logic [REG_W-1:0] src1;
        logic [REG_W-1:0] src2;
        logic useImm;
        logic [IMM_W-1:0] imm;
        logic [DATA_W-1:0] value;
        int gap;
        inUop_t u;
        fd = $fopen("dv/coreTrace.txt", "r");
        if (fd == 0) begin
            runErrors++;
            $display("ERROR: cannot open dv/coreTrace.txt");
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tag);
            if (n != 1) begin
                break;
            end
            if (tag == "#") begin
                n = $fgets(rest, fd);           // Column notes.
            end else if (tag == "U") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h", op, dst, src1, src2, useImm, imm, gap);
                if (n != 7) begin
                    runErrors++;
                    $display("ERROR: malformed uop line in trace");
                end
                u = '{valid: 1'b1, op: opcode_t'(op), dst: dst, src1: src1, src2: src2,
                      useImm: useImm, imm: imm};
                uops.push_back(u);
                gaps.push_back(gap);
            end else if (tag == "C") begin
                n = $fscanf(fd, "%h %h", dst, value);
                if (n != 2) begin
                    runErrors++;
                    $display("ERROR: malformed commit line in trace");
                end
                expDst.push_back(dst);
                expVal.push_back(value);
            end else begin
                runErrors++;
                $display("ERROR: unknown record type in trace");
            end
        end
        $fclose(fd);
    endtask

    task automatic checkCommit();
        if (commitCnt >= expDst.size()) begin
            checkErrors++;
            $display("ERROR: extra commit of sqN %h beyond the expected list", commit.sqN);
        end else begin
            if (commit.sqN !== expSqN) begin
                checkErrors++;
                $display("MISMATCH commit.sqN: got %h expected %h", commit.sqN, expSqN);
            end
            if (commit.dst !== expDst[commitCnt]) begin
                checkErrors++;
                $display("MISMATCH commit.dst: got %h expected %h", commit.dst, expDst[commitCnt]);
            end
            if (commit.value !== expVal[commitCnt]) begin
                checkErrors++;
                $display("MISMATCH commit.value: got %h expected %h", commit.value,
                         expVal[commitCnt]);
            end
        end
        commitCnt++;
        expSqN = expSqN + 1'b1;                 // Wraps with the sqN width.
    endtask

    // --------------------------------------------------
    // Source driver sends one uop per held credit
    initial begin
        int idx;
        int idle;
        inUop = '0;
        idx = 0;
        idle = 0;
        @(negedge rst);
        if (uops.size() > 0) begin
            idle = gaps[0];
        end
        while (idx < uops.size()) begin
            @(posedge clk);
            #2;
            if (idle > 0) begin
                inUop = '0;
                idle--;
            end else if (creditsHeld() > 0) begin
                inUop = uops[idx];
                sentCnt++;
                idx++;
                if (idx < uops.size()) begin
                    idle = gaps[idx];
                end
            end else begin
                inUop = '0;                     // Stalled on credits.
            end
        end
        @(posedge clk);
        #2;
        inUop = '0;
    end

    // Outputs are settled mid-cycle.
    always @(negedge clk) begin
        cycles++;
        if (rst || sentCnt == 0) begin
            if (credit !== 1'b0) begin
                checkErrors++;
                $display("MISMATCH credit: got %h expected %h before the first uop",
                         credit, 1'b0);
            end
            if (commit.valid !== 1'b0) begin
                checkErrors++;
                $display("MISMATCH commit.valid: got %h expected %h before the first uop",
                         commit.valid, 1'b0);
            end
        end else begin
            if (credit === 1'b1) begin
                returnedCnt++;
            end
            if (commit.valid === 1'b1) begin
                checkCommit();
            end
            if (creditsHeld() < 0 || creditsHeld() > DISPATCH_DEPTH) begin
                checkErrors++;
                $display("ERROR: source credit count out of range at %0d", creditsHeld());
            end
        end
    end

    // --------------------------------------------------
    initial begin
        rst = 1'b1;
        loadTrace();
        if (uops.size() == 0 || uops.size() != expDst.size()) begin
            runErrors++;
            $display("ERROR: trace holds %0d uops but %0d commits", uops.size(), expDst.size());
        end
        cycleLimit = 40 * uops.size() + 200;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        while (commitCnt < uops.size() && cycles < cycleLimit) begin
            @(posedge clk);
        end
        if (commitCnt < uops.size()) begin
            runErrors++;
            $display("ERROR: timeout before all commits (%0d of %0d)", commitCnt, uops.size());
        end else begin
            repeat (20) @(posedge clk);         // Catch late or duplicated commits.
        end
        if (returnedCnt != sentCnt) begin
            runErrors++;
            $display("ERROR: %0d uops sent but only %0d credits came back", sentCnt, returnedCnt);
        end
        if (commitCnt != sentCnt) begin
            runErrors++;
            $display("ERROR: %0d uops sent but %0d commits seen", sentCnt, commitCnt);
        end
        $display("Errors: %0d in checks, %0d in run control; %0d of %0d uops committed",
                 checkErrors, runErrors, commitCnt, uops.size());
        if (checkErrors == 0 && runErrors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
hw/corePkg.sv
hw/intAlu.sv
hw/multiplier.sv
hw/issueQueue.sv
hw/reorderBuffer.sv
hw/dispatchCtrl.sv
hw/coreTop.sv
dv/tbCore.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 --top-module tbCore -f list.f -o simCore

output=$(./obj_dir/simCore)
echo "$output"

if echo "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

// ==== dv/coreTrace.txt ====
# U op dst src1 src2 useImm imm gap : one uop in program order, gap = idle cycles before it, hex
# C dst value : expected commit in program order, hex
U 0 1 0 0 1 0007 0
U 0 2 0 0 1 0003 0
U 0 0 1 0 1 0005 1
U 6 3 1 2 0 0000 0
U 4 5 1 0 1 00ff 0
U 0 4 3 0 0 0000 0
U 1 7 4 5 0 0000 0
U 5 6 2 0 1 0004 2
U 6 1 7 6 0 0000 3
U 6 4 6 6 0 0000 0
U 6 5 4 0 1 0003 0
U 6 0 6 0 1 0100 0
U 6 6 5 1 0 0000 0
U 3 2 6 0 0 0000 0
C 1 00000007
C 2 00000003
C 0 0000000c
C 3 00000015
C 5 000000f8
C 4 00000015
C 7 ffffff1d
C 6 00000030
C 1 ffffd570
C 4 00000900
C 5 00001b00
C 0 00003000
C 6 fb82d000
C 2 fb82d000
